//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert --top-module pulse_gen_tb -f sim.f -o pulse_gen_sim
	out=$$(./obj_dir/pulse_gen_sim +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

//--- logic/cmd_parser.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_parser (
	input wire clk_uart,
	input wire resetn,
	input wire [7:0] rx_data,
	input wire rx_valid,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output logic [pulse_cfg_pkg::addr_w-1:0] paddr,
	output logic [31:0] pwdata,
	input wire pready
);
	import pulse_cfg_pkg::*;
	import uart_cmd_pkg::*;

	localparam int cnt_w = $clog2(frame_len);
	// index of the last data byte
	localparam logic [cnt_w-1:0] last_byte = cnt_w'(frame_len - 2);

	parser_state_e state;
	logic [cnt_w-1:0] data_cnt;
	logic discard;
	logic known;
	reg_addr_e opcode_addr;

	// the parser only ever writes
	assign pwrite = 1'b1;

	// opcode to register address
	always_comb begin
		known = 1'b1;
		opcode_addr = addr_period;
		case (rx_data)
			op_period: opcode_addr = addr_period;
			op_p1width: opcode_addr = addr_p1width;
			op_delay: opcode_addr = addr_delay;
			op_p2width: opcode_addr = addr_p2width;
			op_cpmg: opcode_addr = addr_cpmg;
			op_block_time: opcode_addr = addr_block_time;
			op_block_en: opcode_addr = addr_block_en;
			default: known = 1'b0;
		endcase
	end

	always_ff @(posedge clk_uart) begin
		if (resetn) begin
			state <= st_opcode;
			data_cnt <= '0;
			discard <= 1'b0;
			psel <= 1'b0;
			penable <= 1'b0;
		end else begin
			case (state)
				st_opcode: begin
					if (rx_valid) begin
						data_cnt <= '0;
						// unknown opcode still eats its data bytes
						discard <= !known;
						state <= st_data;
					end
				end
				st_data: begin
					if (rx_valid) begin
						data_cnt <= data_cnt + 1'b1;
						if (data_cnt == last_byte) begin
							state <= discard ? st_opcode : st_setup;
							psel <= !discard;
						end
					end
				end
				// one setup cycle, psel only
				st_setup: begin
					penable <= 1'b1;
					state <= st_access;
				end
				// hold until the slave is ready
				st_access: begin
					if (pready) begin
						psel <= 1'b0;
						penable <= 1'b0;
						state <= st_opcode;
					end
				end
				default: state <= st_opcode;
			endcase
		end
	end

	// address and data, big endian word
	always_ff @(posedge clk_uart) begin
		if (rx_valid && state == st_opcode) begin
			paddr <= opcode_addr;
		end
		if (rx_valid && state == st_data) begin
			pwdata <= {pwdata[23:0], rx_data};
		end
	end

endmodule

`default_nettype wire

//--- logic/param_regs.sv
`timescale 1ns/1ps
`default_nettype none

module param_regs (
	input wire clk_uart,
	input wire resetn,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [pulse_cfg_pkg::addr_w-1:0] paddr,
	input wire [31:0] pwdata,
	output logic pready,
	input wire period_start,
	output logic [pulse_cfg_pkg::period_w-1:0] period,
	output logic [pulse_cfg_pkg::time_w-1:0] p1width,
	output logic [pulse_cfg_pkg::time_w-1:0] delay,
	output logic [pulse_cfg_pkg::time_w-1:0] p2width,
	output logic [pulse_cfg_pkg::cpmg_w-1:0] cpmg,
	output logic [pulse_cfg_pkg::time_w-1:0] block_time,
	output logic block_en
);
	import pulse_cfg_pkg::*;

	// shadow set, written over apb
	logic [period_w-1:0] sh_period;
	logic [time_w-1:0] sh_p1width;
	logic [time_w-1:0] sh_delay;
	logic [time_w-1:0] sh_p2width;
	logic [cpmg_w-1:0] sh_cpmg;
	logic [time_w-1:0] sh_block_time;
	logic sh_block_en;
	logic wr_en;

	// completing cycle of a write transfer
	assign wr_en = psel && penable && pready && pwrite;

	// one wait state, ready in the second access cycle
	always_ff @(posedge clk_uart) begin
		if (resetn) begin
			pready <= 1'b0;
		end else begin
			pready <= psel && penable && !pready;
		end
	end

	always_ff @(posedge clk_uart) begin
		if (resetn) begin
			sh_period <= def_period;
			sh_p1width <= def_p1width;
			sh_delay <= def_delay;
			sh_p2width <= def_p2width;
			sh_cpmg <= def_cpmg;
			sh_block_time <= def_block_time;
			sh_block_en <= def_block_en;
		end else if (wr_en) begin
			// upper bits beyond the field width are dropped
			case (reg_addr_e'(paddr))
				addr_period: sh_period <= pwdata[period_w-1:0];
				addr_p1width: sh_p1width <= pwdata[time_w-1:0];
				addr_delay: sh_delay <= pwdata[time_w-1:0];
				addr_p2width: sh_p2width <= pwdata[time_w-1:0];
				addr_cpmg: sh_cpmg <= pwdata[cpmg_w-1:0];
				addr_block_time: sh_block_time <= pwdata[time_w-1:0];
				addr_block_en: sh_block_en <= pwdata[0];
				default: sh_block_en <= sh_block_en;
			endcase
		end
	end

	// whole set moves at once, so a running period never mixes values
	always_ff @(posedge clk_uart) begin
		if (resetn) begin
			period <= def_period;
			p1width <= def_p1width;
			delay <= def_delay;
			p2width <= def_p2width;
			cpmg <= def_cpmg;
			block_time <= def_block_time;
			block_en <= def_block_en;
		end else if (period_start) begin
			period <= sh_period;
			p1width <= sh_p1width;
			delay <= sh_delay;
			p2width <= sh_p2width;
			cpmg <= sh_cpmg;
			block_time <= sh_block_time;
			block_en <= sh_block_en;
		end
	end

endmodule

`default_nettype wire

//--- logic/pulse_cfg_pkg.sv
`default_nettype none

package pulse_cfg_pkg;

	// field widths of the pulse parameters
	localparam int period_w = 32;
	localparam int time_w = 16;
	localparam int cpmg_w = 8;

	// apb address width
	localparam int addr_w = 3;

	// register map, one word per parameter
	typedef enum logic [addr_w-1:0] {
		addr_period = 3'd0,
		addr_p1width = 3'd1,
		addr_delay = 3'd2,
		addr_p2width = 3'd3,
		addr_cpmg = 3'd4,
		addr_block_time = 3'd5,
		addr_block_en = 3'd6
	} reg_addr_e;

	// values loaded by reset, in clk_uart cycles
	localparam logic [period_w-1:0] def_period = 32'd10000;
	localparam logic [time_w-1:0] def_p1width = 16'd30;
	localparam logic [time_w-1:0] def_delay = 16'd200;
	localparam logic [time_w-1:0] def_p2width = 16'd60;
	// three refocusing pulses
	localparam logic [cpmg_w-1:0] def_cpmg = 8'd3;
	localparam logic [time_w-1:0] def_block_time = 16'd10;
	// blanking on
	localparam logic def_block_en = 1'b1;

endpackage

`default_nettype wire

//--- logic/pulse_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pulse_gen #(
	parameter int clks_per_bit = 16,
	parameter int sync_width = 4
) (
	input wire clk_uart,
	input wire resetn,
	input wire rx,
	output wire sync,
	output wire pulse,
	output wire block,
	output wire recv,
	output wire [7:0] led
);
	import pulse_cfg_pkg::*;

	logic [7:0] rx_data;
	logic rx_valid;
	// apb between parser and register file
	logic psel;
	logic penable;
	logic pwrite;
	logic [addr_w-1:0] paddr;
	logic [31:0] pwdata;
	logic pready;
	// active parameter set
	logic [period_w-1:0] period;
	logic [time_w-1:0] p1width;
	logic [time_w-1:0] delay;
	logic [time_w-1:0] p2width;
	logic [cpmg_w-1:0] cpmg;
	logic [time_w-1:0] block_time;
	logic block_en;
	logic period_start;

	// byte strobe made visible on a pin
	assign recv = rx_valid;

	uart_rx #(
		.clks_per_bit(clks_per_bit)
	) uart_rx_i (
		.clk_uart(clk_uart),
		.resetn(resetn),
		.rx(rx),
		.rx_data(rx_data),
		.rx_valid(rx_valid)
	);

	cmd_parser cmd_parser_i (
		.clk_uart(clk_uart),
		.resetn(resetn),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.pready(pready)
	);

	param_regs param_regs_i (
		.clk_uart(clk_uart),
		.resetn(resetn),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.pready(pready),
		.period_start(period_start),
		.period(period),
		.p1width(p1width),
		.delay(delay),
		.p2width(p2width),
		.cpmg(cpmg),
		.block_time(block_time),
		.block_en(block_en)
	);

	pulse_sequencer #(
		.sync_width(sync_width)
	) pulse_sequencer_i (
		.clk_uart(clk_uart),
		.resetn(resetn),
		.period(period),
		.p1width(p1width),
		.delay(delay),
		.p2width(p2width),
		.cpmg(cpmg),
		.block_time(block_time),
		.block_en(block_en),
		.period_start(period_start),
		.sync(sync),
		.pulse(pulse),
		.block(block),
		.led(led)
	);

endmodule

`default_nettype wire

//--- logic/pulse_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module pulse_sequencer #(
	parameter int sync_width = 4
) (
	input wire clk_uart,
	input wire resetn,
	input wire [pulse_cfg_pkg::period_w-1:0] period,
	input wire [pulse_cfg_pkg::time_w-1:0] p1width,
	input wire [pulse_cfg_pkg::time_w-1:0] delay,
	input wire [pulse_cfg_pkg::time_w-1:0] p2width,
	input wire [pulse_cfg_pkg::cpmg_w-1:0] cpmg,
	input wire [pulse_cfg_pkg::time_w-1:0] block_time,
	input wire block_en,
	output logic period_start,
	output logic sync,
	output logic pulse,
	output logic block,
	output logic [7:0] led
);
	import pulse_cfg_pkg::*;

	logic [period_w-1:0] cnt;
	logic [period_w-1:0] cnt_n;
	logic wrap;
	// count of the next pulse edge
	logic [period_w-1:0] next_edge;
	logic [period_w-1:0] edge_n;
	logic [period_w-1:0] gap;
	// refocusing pulses started this period
	logic [cpmg_w-1:0] pulse_idx;
	logic [cpmg_w-1:0] idx_n;
	logic hit;
	logic pulse_n;
	// blanking cycles left after a falling edge
	logic [time_w-1:0] tail;
	logic [time_w-1:0] tail_n;

	assign period_start = (cnt == '0);

	// outputs are registered from the next count, so they line up with cnt
	always_comb begin
		wrap = (cnt == period - 1'b1);
		cnt_n = wrap ? '0 : cnt + 1'b1;
		// first gap is delay, between refocusing pulses it is 2*delay
		gap = (pulse_idx == '0) ? period_w'(delay) : period_w'(delay) << 1;
		if (pulse && pulse_idx == '0) begin
			hit = (cnt_n == period_w'(p1width));
		end else begin
			hit = (cnt_n == next_edge);
		end
		pulse_n = pulse;
		edge_n = next_edge;
		idx_n = pulse_idx;
		if (cnt_n == '0) begin
			// excitation pulse at the top of every period
			pulse_n = 1'b1;
			edge_n = '0;
			idx_n = '0;
		end else if (hit) begin
			if (pulse) begin
				pulse_n = 1'b0;
				// no more edges once cpmg pulses are done
				if (pulse_idx < cpmg) begin
					edge_n = cnt_n + gap;
				end
			end else begin
				pulse_n = 1'b1;
				idx_n = pulse_idx + 1'b1;
				edge_n = cnt_n + period_w'(p2width);
			end
		end
		if (pulse && !pulse_n) begin
			tail_n = block_time;
		end else if (tail != '0) begin
			tail_n = tail - 1'b1;
		end else begin
			tail_n = '0;
		end
	end

	always_ff @(posedge clk_uart) begin
		if (resetn) begin
			// all ones, so the first count after reset is 0
			cnt <= '1;
			next_edge <= '0;
			pulse_idx <= '0;
			pulse <= 1'b0;
			tail <= '0;
			sync <= 1'b0;
			block <= 1'b0;
			led <= '0;
		end else begin
			cnt <= cnt_n;
			next_edge <= edge_n;
			pulse_idx <= idx_n;
			pulse <= pulse_n;
			tail <= tail_n;
			sync <= (cnt_n < period_w'(sync_width));
			block <= block_en && (pulse_n || tail_n != '0);
			// completed periods
			if (wrap) begin
				led <= led + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/uart_cmd_pkg.sv
`default_nettype none

package uart_cmd_pkg;

	// first byte of a frame, ascii letters and digits
	typedef enum logic [7:0] {
		op_period = 8'h50,
		op_p1width = 8'h31,
		op_delay = 8'h44,
		op_p2width = 8'h32,
		op_cpmg = 8'h43,
		op_block_time = 8'h42,
		op_block_en = 8'h45
	} cmd_op_e;

	// opcode plus four data bytes, msb first
	localparam int frame_len = 5;

	// parser fsm
	typedef enum logic [1:0] {
		st_opcode,
		st_data,
		st_setup,
		st_access
	} parser_state_e;

endpackage

`default_nettype wire

//--- logic/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
	parameter int clks_per_bit = 16
) (
	input wire clk_uart,
	input wire resetn,
	input wire rx,
	output logic [7:0] rx_data,
	output logic rx_valid
);
	localparam int cnt_w = $clog2(clks_per_bit);
	localparam logic [cnt_w-1:0] half_tick = cnt_w'(clks_per_bit / 2 - 1);
	localparam logic [cnt_w-1:0] full_tick = cnt_w'(clks_per_bit - 1);

	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_bits,
		rx_stop
	} rx_state_e;

	rx_state_e state;
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic [cnt_w-1:0] tick;
	logic [2:0] bit_idx;

	// two-flop synchroniser, plus one stage for edge detect
	// line idles high
	always_ff @(posedge clk_uart) begin
		if (resetn) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge clk_uart) begin
		if (resetn) begin
			state <= rx_idle;
			tick <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			// strobe lasts a single cycle
			rx_valid <= 1'b0;
			tick <= tick + 1'b1;
			case (state)
				rx_idle: begin
					tick <= '0;
					// falling edge starts a frame
					if (rx_prev && !rx_sync) begin
						state <= rx_start;
					end
				end
				rx_start: begin
					// recheck at mid start bit, a glitch goes back to idle
					if (tick == half_tick) begin
						tick <= '0;
						bit_idx <= '0;
						state <= rx_sync ? rx_idle : rx_bits;
					end
				end
				rx_bits: begin
					if (tick == full_tick) begin
						tick <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= rx_stop;
						end
					end
				end
				rx_stop: begin
					// low stop bit drops the byte
					if (tick == full_tick) begin
						rx_valid <= rx_sync;
						state <= rx_idle;
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

	// lsb arrives first, shift in from the top
	always_ff @(posedge clk_uart) begin
		if (state == rx_bits && tick == full_tick) begin
			rx_data <= {rx_sync, rx_data[7:1]};
		end
	end

endmodule

`default_nettype wire

//--- sim.f
logic/pulse_cfg_pkg.sv
logic/uart_cmd_pkg.sv
logic/uart_rx.sv
logic/cmd_parser.sv
logic/param_regs.sv
logic/pulse_sequencer.sv
logic/pulse_gen.sv
tb/pulse_gen_assertions.sv
tb/pulse_gen_tb.sv

//--- tb/pulse_gen_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module pulse_gen_assertions #(
	parameter int sync_width = 4
) (
	input wire clk_uart,
	input wire resetn,
	input wire [pulse_cfg_pkg::period_w-1:0] period,
	input wire [pulse_cfg_pkg::time_w-1:0] p1width,
	input wire [pulse_cfg_pkg::time_w-1:0] delay,
	input wire [pulse_cfg_pkg::time_w-1:0] p2width,
	input wire [pulse_cfg_pkg::cpmg_w-1:0] cpmg,
	input wire [pulse_cfg_pkg::time_w-1:0] block_time,
	input wire block_en,
	input wire period_start,
	input wire sync,
	input wire pulse,
	input wire block,
	input wire [7:0] led
);
	import pulse_cfg_pkg::*;

	// failed checks, read by the testbench at the end
	int fail_count = 0;

	// reference count, independent of the sequencer
	logic run;
	logic run_d;
	logic [period_w-1:0] m_cnt;
	logic wrap;
	logic wrap_d;
	logic [7:0] led_d;
	// blanking enable as seen one cycle late by the registered output
	logic blk_en_d;
	logic pulse_d;
	logic exp_p;
	logic exp_block;
	// consecutive low cycles of the expected pulse
	int low_prev;
	int low_now;
	// rising edges seen so far in this period
	int rises_prev;
	int rises_now;

	// pulse level at count c, straight from the start rule
	function automatic logic pulse_expected(
		input logic [31:0] c,
		input logic [31:0] p1w,
		input logic [31:0] d,
		input logic [31:0] p2w,
		input logic [31:0] n
	);
		logic [31:0] start;
		logic hit;
		int k;
		// excitation pulse
		hit = (c < p1w);
		start = p1w + d;
		// refocusing pulse k starts at p1w + d + (k-1)(p2w + 2d)
		for (k = 1; k <= int'(n); k++) begin
			if (c >= start && c < start + p2w) begin
				hit = 1'b1;
			end
			start = start + p2w + d + d;
		end
		return hit;
	endfunction

	always_comb begin
		exp_p = pulse_expected(m_cnt, 32'(p1width), 32'(delay), 32'(p2width), 32'(cpmg));
		low_now = exp_p ? 0 : low_prev + 1;
		// pulse plus block_time cycles after each falling edge
		exp_block = blk_en_d && (exp_p || (low_now >= 1 && low_now <= int'(block_time)));
		wrap = run && (m_cnt == period - 32'd1);
		rises_now = (m_cnt == '0) ? 0 : rises_prev;
		if (pulse && !pulse_d) begin
			rises_now = rises_now + 1;
		end
	end

	always_ff @(posedge clk_uart) begin
		if (resetn) begin
			run <= 1'b0;
			run_d <= 1'b0;
			m_cnt <= '0;
			wrap_d <= 1'b0;
			led_d <= '0;
			blk_en_d <= 1'b0;
			pulse_d <= 1'b0;
			low_prev <= 0;
			rises_prev <= 0;
		end else begin
			run <= 1'b1;
			run_d <= run;
			// count 0 on the first cycle after reset
			m_cnt <= (!run || wrap) ? '0 : m_cnt + 32'd1;
			wrap_d <= wrap;
			led_d <= led;
			blk_en_d <= block_en;
			pulse_d <= pulse;
			low_prev <= low_now;
			rises_prev <= rises_now;
		end
	end

	a_period_start: assert property (@(posedge clk_uart) disable iff (resetn)
		run |-> period_start == (m_cnt == '0))
	else begin
		fail_count++;
		$error("** Error %0t period_start dut=%b exp=%b", $time,
			$sampled(period_start), $sampled(m_cnt == '0));
	end

	a_sync: assert property (@(posedge clk_uart) disable iff (resetn)
		run |-> sync == (m_cnt < period_w'(sync_width)))
	else begin
		fail_count++;
		$error("** Error %0t sync dut=%b exp=%b", $time,
			$sampled(sync), $sampled(m_cnt < period_w'(sync_width)));
	end

	// edges and widths both follow from the level check
	a_pulse: assert property (@(posedge clk_uart) disable iff (resetn)
		run |-> pulse == exp_p)
	else begin
		fail_count++;
		$error("** Error %0t pulse dut=%b exp=%b", $time, $sampled(pulse), $sampled(exp_p));
	end

	a_pulse_count: assert property (@(posedge clk_uart) disable iff (resetn)
		wrap |-> rises_now == int'(cpmg) + 1)
	else begin
		fail_count++;
		$error("** Error %0t pulse count dut=%0d exp=%0d", $time,
			$sampled(rises_now), $sampled(int'(cpmg) + 1));
	end

	a_block: assert property (@(posedge clk_uart) disable iff (resetn)
		run |-> block == exp_block)
	else begin
		fail_count++;
		$error("** Error %0t block dut=%b exp=%b", $time, $sampled(block), $sampled(exp_block));
	end

	// one step per wrap, steady otherwise
	a_led: assert property (@(posedge clk_uart) disable iff (resetn)
		run_d |-> led == (wrap_d ? led_d + 8'd1 : led_d))
	else begin
		fail_count++;
		$error("** Error %0t led dut=%0d exp=%0d", $time, $sampled(led),
			$sampled(wrap_d ? led_d + 8'd1 : led_d));
	end

endmodule

bind pulse_sequencer pulse_gen_assertions #(
	.sync_width(sync_width)
) wave_check_i (
	.clk_uart(clk_uart),
	.resetn(resetn),
	.period(period),
	.p1width(p1width),
	.delay(delay),
	.p2width(p2width),
	.cpmg(cpmg),
	.block_time(block_time),
	.block_en(block_en),
	.period_start(period_start),
	.sync(sync),
	.pulse(pulse),
	.block(block),
	.led(led)
);

`default_nettype wire

//--- tb/pulse_gen_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pulse_gen_tb;
	import uart_cmd_pkg::*;

	localparam int clks_per_bit = 16;
	localparam int sync_width = 4;
	// longest period in use is the reset default
	localparam int longest_period = 10000;
	localparam int frame_cycles = frame_len * 10 * clks_per_bit;
	// 10 random, block_time, unknown, one after it, blanking off and on
	localparam int n_frames = 15;
	// each frame waits at most one period, plus defaults and blanking hold
	localparam int timeout_cycles = n_frames * (frame_cycles + longest_period)
		+ 3 * longest_period;

	logic clk_uart;
	logic resetn;
	logic rx;
	wire sync;
	wire pulse;
	wire block;
	wire recv;
	wire [7:0] led;

	int seed = 50426;
	int errors = 0;
	int assert_fails;
	int bytes_sent = 0;
	int recv_count = 0;
	int round;

	// expected active set, starts at the documented defaults
	logic [31:0] exp_period = 32'd10000;
	logic [31:0] exp_p1width = 32'd30;
	logic [31:0] exp_delay = 32'd200;
	logic [31:0] exp_p2width = 32'd60;
	logic [31:0] exp_cpmg = 32'd3;
	logic [31:0] exp_block_time = 32'd10;
	logic [31:0] exp_block_en = 32'd1;

	pulse_gen #(
		.clks_per_bit(clks_per_bit),
		.sync_width(sync_width)
	) dut_i (
		.clk_uart(clk_uart),
		.resetn(resetn),
		.rx(rx),
		.sync(sync),
		.pulse(pulse),
		.block(block),
		.recv(recv),
		.led(led)
	);

	initial begin
		clk_uart = 1'b0;
		forever #10 clk_uart = ~clk_uart;
	end

	// one count per cycle of recv
	always @(posedge clk_uart) begin
		if (resetn) begin
			recv_count <= 0;
		end else if (recv) begin
			recv_count <= recv_count + 1;
		end
	end

	// start bit, eight data bits lsb first, stop bit
	task send_byte(input logic [7:0] data);
		logic [9:0] bits;
		int i;
		bits = {1'b1, data, 1'b0};
		for (i = 0; i < 10; i++) begin
			rx = bits[i];
			repeat (clks_per_bit) @(negedge clk_uart);
		end
		bytes_sent++;
	endtask

	// next count 0, then one more cycle for the active set to load
	task wait_boundary;
		@(negedge clk_uart);
		while (!dut_i.period_start) begin
			@(negedge clk_uart);
		end
		@(negedge clk_uart);
	endtask

	task check_field(input string name, input logic [31:0] dut_val, input logic [31:0] exp_val);
		assert (dut_val == exp_val)
		else begin
			errors++;
			$display("** Error %0t %s dut=%0d exp=%0d", $time, name, dut_val, exp_val);
		end
	endtask

	task check_params;
		check_field("period", 32'(dut_i.period), exp_period);
		check_field("p1width", 32'(dut_i.p1width), exp_p1width);
		check_field("delay", 32'(dut_i.delay), exp_delay);
		check_field("p2width", 32'(dut_i.p2width), exp_p2width);
		check_field("cpmg", 32'(dut_i.cpmg), exp_cpmg);
		check_field("block_time", 32'(dut_i.block_time), exp_block_time);
		check_field("block_en", 32'(dut_i.block_en), exp_block_en);
	endtask

	// opcode then the word msb first, wait for the apb write and the next period
	task apply_frame(input logic [7:0] op, input logic [31:0] value);
		send_byte(op);
		send_byte(value[31:24]);
		send_byte(value[23:16]);
		send_byte(value[15:8]);
		send_byte(value[7:0]);
		while (recv_count < bytes_sent || dut_i.psel) begin
			@(negedge clk_uart);
		end
		wait_boundary();
		check_params();
	endtask

	initial begin : stimulus
		rx = 1'b1;
		resetn = 1'b1;
		repeat (5) @(negedge clk_uart);
		resetn = 1'b0;
		check_params();
		// first boundary plus one whole default period
		repeat (2) wait_boundary();

		// small values so every train fits inside the period
		for (round = 0; round < 2; round++) begin
			exp_period = 32'd3000 + ($random(seed) & 1023);
			apply_frame(op_period, exp_period);
			exp_p1width = 32'd2 + ($random(seed) & 31);
			apply_frame(op_p1width, exp_p1width);
			exp_delay = 32'd1 + ($random(seed) & 63);
			apply_frame(op_delay, exp_delay);
			exp_p2width = 32'd2 + ($random(seed) & 63);
			apply_frame(op_p2width, exp_p2width);
			exp_cpmg = 32'd1 + ($random(seed) & 7);
			apply_frame(op_cpmg, exp_cpmg);
		end
		exp_block_time = 32'd1 + ($random(seed) & 15);
		apply_frame(op_block_time, exp_block_time);

		// 'Z' is no opcode, nothing may change
		apply_frame(8'h5a, 32'd7);
		exp_p1width = 32'd2 + ($random(seed) & 31);
		apply_frame(op_p1width, exp_p1width);

		// blanking off for a whole period, then back on
		exp_block_en = 32'd0;
		apply_frame(op_block_en, 32'd0);
		wait_boundary();
		exp_block_en = 32'd1;
		apply_frame(op_block_en, 32'd1);

		assert (recv_count == bytes_sent)
		else begin
			errors++;
			$display("** Error %0t recv dut=%0d exp=%0d", $time, recv_count, bytes_sent);
		end
		assert_fails = dut_i.pulse_sequencer_i.wave_check_i.fail_count;
		$display("errors: %0d testbench, %0d assertion", errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin : watchdog
		repeat (timeout_cycles) @(posedge clk_uart);
		$display("simulation timed out after %0d clock cycles", timeout_cycles);
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire
